// ==== Makefile ====
TOP := tb_coco_tape
RTL := $(shell grep '^rtl/' project.f)

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "sim failed" sim.log; then \
		exit 1; \
	fi

lint:
	verilator --lint-only -Wall --top-module coco_tape_top $(RTL)

clean:
	rm -rf obj_dir sim.log

// ==== dv/tape_arbiter_checker.sv ====
// Concurrent assertions on the tape memory arbiter
// Port exclusivity, stable stalled requests, read data valid timing

`timescale 1ns/1ps

module tape_arbiter_checker #(
	parameter int TAPE_ADDR_W = 12
) (
	input logic                                  clk_sys,
	input logic                                  i_reset,
	input logic                                  i_ram_we,
	input logic                                  i_rd_grant,
	input logic                                  i_load_valid,
	input logic                                  i_load_ready,
	input logic [TAPE_ADDR_W-1:0]                i_load_addr,
	input logic [coco_tape_pkg::TAPE_DATA_W-1:0] i_load_data,
	input logic                                  i_rd_valid,
	input logic                                  i_rd_ready,
	input logic [TAPE_ADDR_W-1:0]                i_rd_addr,
	input logic                                  i_rd_data_valid
);

	//////////////////////////////////////////////////
	// Single RAM port
	//////////////////////////////////////////////////

	a_port_exclusive: assert property (@(posedge clk_sys) disable iff (i_reset)
		!(i_ram_we && i_rd_grant))
		else $error("RAM write and player read granted in the same cycle");

	//////////////////////////////////////////////////
	// Stalled requests hold
	//////////////////////////////////////////////////

	// Loader keeps address and data until its write is taken
	a_load_stable: assert property (@(posedge clk_sys) disable iff (i_reset)
		(i_load_valid && !i_load_ready) |=>
		(i_load_valid && $stable(i_load_addr) && $stable(i_load_data)))
		else $error("Stalled loader request changed before it was accepted");

	// Player keeps its read address
	a_rd_stable: assert property (@(posedge clk_sys) disable iff (i_reset)
		(i_rd_valid && !i_rd_ready) |=> (i_rd_valid && $stable(i_rd_addr)))
		else $error("Stalled player read changed before it was accepted");

	//////////////////////////////////////////////////
	// Read data valid timing
	//////////////////////////////////////////////////

	a_rdv_follows: assert property (@(posedge clk_sys) disable iff (i_reset)
		i_rd_grant |=> i_rd_data_valid)
		else $error("Read data valid missing one cycle after a read grant");

	a_rdv_only_after_grant: assert property (@(posedge clk_sys) disable iff (i_reset)
		i_rd_data_valid |-> $past(i_rd_grant))
		else $error("Read data valid without a read grant the cycle before");

endmodule

bind tape_mem_arbiter tape_arbiter_checker #(
	.TAPE_ADDR_W (TAPE_ADDR_W)
) tape_arbiter_checker_inst (
	.clk_sys         (clk_sys),
	.i_reset         (i_reset),
	.i_ram_we        (ram_we),
	.i_rd_grant      (rd_grant),
	.i_load_valid    (i_load_valid),
	.i_load_ready    (o_load_ready),
	.i_load_addr     (i_load_addr),
	.i_load_data     (i_load_data),
	.i_rd_valid      (i_rd_valid),
	.i_rd_ready      (o_rd_ready),
	.i_rd_addr       (i_rd_addr),
	.i_rd_data_valid (o_rd_data_valid)
);

// ==== dv/tb_coco_tape.sv ====
// Testbench for the cassette path top level
// Reset, tape load and playback, contention, ADC slicer, machine select, audio mix
// Reference models for tape bitstream, slicer, reset sequencer and audio word

`timescale 1ns/1ps

module tb_coco_tape;

	localparam int AVG_LOG2      = 4;
	localparam int ADC_THRESHOLD = 100;
	localparam int TAPE_ADDR_W   = 12;
	localparam int BIT_PERIOD    = 16;
	localparam int RESET_STRETCH = 15;

	localparam int LOAD_BYTES    = 64;
	// Bits checked alone, then the same again under contention
	localparam int PLAY_BITS     = 256;
	// Enough writes to keep the loader busy over most of the contention window
	localparam int UPPER_BYTES   = 900;
	localparam int ADC_SAMPLES   = 80;
	localparam int AUDIO_SAMPLES = 20;
	localparam int RUN_CYCLES    = 10 + LOAD_BYTES * 8 + 2 * PLAY_BITS * BIT_PERIOD
		+ UPPER_BYTES * 8 + ADC_SAMPLES * 3 + 5 * (RESET_STRETCH + 4) + AUDIO_SAMPLES * 4;
	localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES + 500;

	logic                                  clk_sys;
	logic                                  i_reset;
	logic [1:0]                            i_machine;
	logic                                  i_hard_toggle;
	logic                                  i_disk_sel;
	logic                                  i_load_valid;
	logic [TAPE_ADDR_W-1:0]                i_load_addr;
	logic [coco_tape_pkg::TAPE_DATA_W-1:0] i_load_data;
	logic                                  i_relay;
	logic                                  i_rewind;
	logic                                  i_adc_valid;
	logic [coco_tape_pkg::ADC_W-1:0]       i_adc_data;
	logic                                  i_tape_src_adc;
	logic                                  i_tape_monitor;
	logic [coco_tape_pkg::SOUND_W-1:0]     i_sound;
	logic                                  i_sndout;
	logic                                  o_load_ready;
	logic                                  o_cas_bit;
	logic [15:0]                           o_audio;
	logic                                  o_core_reset;
	logic                                  o_hard_reset;
	logic                                  o_dragon;
	logic                                  o_dragon64;
	logic                                  o_disk_cart_en;

	// Tape memory as the loader sees it
	logic [7:0] model_mem [2 ** TAPE_ADDR_W];
	int         seed;
	int         errors;
	int         tests;
	int         tests_bad;
	// Loader handshakes seen at the clock edge
	int         handshakes;

	coco_tape_top #(
		.AVG_LOG2      (AVG_LOG2),
		.ADC_THRESHOLD (ADC_THRESHOLD),
		.TAPE_ADDR_W   (TAPE_ADDR_W),
		.BIT_PERIOD    (BIT_PERIOD),
		.RESET_STRETCH (RESET_STRETCH)
	) coco_tape_top_inst (
		.clk_sys        (clk_sys),
		.i_reset        (i_reset),
		.i_machine      (i_machine),
		.i_hard_toggle  (i_hard_toggle),
		.i_disk_sel     (i_disk_sel),
		.i_load_valid   (i_load_valid),
		.i_load_addr    (i_load_addr),
		.i_load_data    (i_load_data),
		.i_relay        (i_relay),
		.i_rewind       (i_rewind),
		.i_adc_valid    (i_adc_valid),
		.i_adc_data     (i_adc_data),
		.i_tape_src_adc (i_tape_src_adc),
		.i_tape_monitor (i_tape_monitor),
		.i_sound        (i_sound),
		.i_sndout       (i_sndout),
		.o_load_ready   (o_load_ready),
		.o_cas_bit      (o_cas_bit),
		.o_audio        (o_audio),
		.o_core_reset   (o_core_reset),
		.o_hard_reset   (o_hard_reset),
		.o_dragon       (o_dragon),
		.o_dragon64     (o_dragon64),
		.o_disk_cart_en (o_disk_cart_en)
	);

	// 40 ns clock
	always #20 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// Reporting
	//////////////////////////////////////////////////

	task automatic log_mismatch(input string msg);
		begin
			$display("Mismatch at time %0t: %s", $time, msg);
			errors++;
		end
	endtask

	task automatic report_failure(input string msg);
		begin
			$display("Error at time %0t: %s", $time, msg);
			errors++;
		end
	endtask

	task automatic close_test(input string name, input int mark);
		begin
			tests++;
			if (errors > mark)
				tests_bad++;
			$display("Test %s finished with %0d errors", name, errors - mark);
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	// A write lands on the edge where valid and ready are both high
	always @(posedge clk_sys)
	begin
		if (!i_reset && i_load_valid && o_load_ready)
			handshakes++;
	end

	// One loader write with a random idle gap in front, held until ready
	task automatic write_byte(input int addr, input logic [7:0] data);
		int guard;
		int gap;
		begin
			guard = 0;
			gap   = {$random(seed)} % 3;
			repeat (gap) @(negedge clk_sys);
			@(negedge clk_sys);
			i_load_valid = 1'b1;
			i_load_addr  = TAPE_ADDR_W'(addr);
			i_load_data  = data;
			// Ready settles after the drive edge so it is sampled mid low phase
			#5;
			while (!o_load_ready && guard < 8)
			begin
				@(negedge clk_sys);
				#5;
				guard++;
			end
			if (o_load_ready)
				model_mem[addr] = data;
			else
				report_failure($sformatf("loader write to address %0d was never accepted", addr));
			@(negedge clk_sys);
			i_load_valid = 1'b0;
		end
	endtask

	// Mid-bit sample of each tape bit, MSB first per byte
	task automatic compare_bitstream(input int first, input int count);
		logic exp_bit;
		begin
			for (int n = first; n < first + count; n++)
			begin
				repeat (BIT_PERIOD) @(negedge clk_sys);
				exp_bit = model_mem[n / 8][7 - (n % 8)];
				if (o_cas_bit !== exp_bit)
					log_mismatch($sformatf("tape bit %0d is %b, expected %b", n, o_cas_bit, exp_bit));
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic check_reset();
		int mark;
		begin
			mark = errors;
			repeat (5)
			begin
				@(negedge clk_sys);
				if (o_load_ready || o_hard_reset || o_cas_bit || o_audio != 16'h0)
					log_mismatch("outputs not at their reset values during reset");
				if (!o_core_reset)
					log_mismatch("o_core_reset low during reset");
			end
			i_reset = 1'b0;
			@(negedge clk_sys);
			if (o_load_ready || o_hard_reset || o_cas_bit || o_audio != 16'h0)
				log_mismatch("outputs not at their reset values after reset");
			if (o_core_reset)
				log_mismatch("o_core_reset still high with no machine change");
			close_test("reset", mark);
		end
	endtask

	task automatic load_and_play();
		int mark;
		int start;
		int guard;
		begin
			mark  = errors;
			start = handshakes;
			// Leading byte has its MSB set so the first rise marks bit 0
			for (int i = 0; i < LOAD_BYTES; i++)
				write_byte(i, (i == 0) ? 8'hA5 : 8'($random(seed)));
			if (handshakes - start != LOAD_BYTES)
				log_mismatch($sformatf("%0d handshakes for %0d writes", handshakes - start,
					LOAD_BYTES));
			@(negedge clk_sys);
			i_rewind = 1'b1;
			@(negedge clk_sys);
			i_rewind = 1'b0;
			i_relay  = 1'b1;
			guard    = 0;
			while (o_cas_bit !== 1'b1 && guard < 200)
			begin
				@(negedge clk_sys);
				guard++;
			end
			if (o_cas_bit !== 1'b1)
				report_failure("o_cas_bit never rose after the relay turned on");
			else
			begin
				repeat (BIT_PERIOD / 2) @(negedge clk_sys);
				if (o_cas_bit !== model_mem[0][7])
					log_mismatch("tape bit 0 wrong at mid-bit");
				compare_bitstream(1, PLAY_BITS - 1);
			end
			close_test("load_and_play", mark);
		end
	endtask

	// Upper half writes race the player for the RAM port
	task automatic load_during_play();
		int mark;
		int start;
		begin
			mark  = errors;
			start = handshakes;
			fork
				compare_bitstream(PLAY_BITS, PLAY_BITS);
				begin
					for (int i = 0; i < UPPER_BYTES; i++)
						write_byte(2 ** (TAPE_ADDR_W - 1) + ({$random(seed)} % 2 ** (TAPE_ADDR_W - 1)),
							8'($random(seed)));
				end
			join
			if (handshakes - start != UPPER_BYTES)
				log_mismatch($sformatf("%0d handshakes for %0d upper half writes",
					handshakes - start, UPPER_BYTES));
			close_test("load_during_play", mark);
		end
	endtask

	task automatic slice_adc();
		int   mark;
		int   hist [2 ** AVG_LOG2];
		int   total;
		int   avg;
		int   ptr;
		int   s;
		int   step;
		logic exp_bit;
		begin
			mark    = errors;
			total   = 0;
			avg     = 0;
			ptr     = 0;
			s       = 2048;
			exp_bit = 1'b0;
			for (int i = 0; i < 2 ** AVG_LOG2; i++)
				hist[i] = 0;
			@(negedge clk_sys);
			i_relay        = 1'b0;
			i_tape_src_adc = 1'b1;
			for (int k = 0; k < ADC_SAMPLES; k++)
			begin
				// Random walk clamped to the converter range
				step = $random(seed) % 401;
				s    = s + step;
				if (s < 0)
					s = 0;
				if (s > 4095)
					s = 4095;
				@(negedge clk_sys);
				i_adc_valid = 1'b1;
				i_adc_data  = coco_tape_pkg::ADC_W'(s);
				// Hysteresis against the average before this sample
				if (s + ADC_THRESHOLD < avg)
					exp_bit = 1'b1;
				else if (s > avg + ADC_THRESHOLD)
					exp_bit = 1'b0;
				total     = total + s - hist[ptr];
				hist[ptr] = s;
				ptr       = (ptr + 1) % (2 ** AVG_LOG2);
				avg       = total >> AVG_LOG2;
				@(negedge clk_sys);
				i_adc_valid = 1'b0;
				@(negedge clk_sys);
				if (o_cas_bit !== exp_bit)
					log_mismatch($sformatf("slicer bit %b for sample %0d, expected %b",
						o_cas_bit, s, exp_bit));
			end
			close_test("slice_adc", mark);
		end
	endtask

	// One machine or hard reset event, then the stretch and decode checks
	task automatic change_machine(input logic [1:0] mach, input logic hard);
		int   core_cnt;
		int   hard_cnt;
		int   guard;
		logic hard_first;
		logic disk;
		begin
			core_cnt = 0;
			hard_cnt = 0;
			guard    = 0;
			@(negedge clk_sys);
			disk       = 1'($random(seed));
			i_disk_sel = disk;
			i_machine  = mach;
			if (hard)
				i_hard_toggle = !i_hard_toggle;
			@(negedge clk_sys);
			hard_first = o_hard_reset;
			while (o_core_reset && guard < 4 * RESET_STRETCH)
			begin
				core_cnt++;
				if (o_hard_reset)
					hard_cnt++;
				@(negedge clk_sys);
				guard++;
			end
			if (core_cnt != RESET_STRETCH)
				log_mismatch($sformatf("core reset lasted %0d cycles for machine %0d",
					core_cnt, mach));
			if (hard && (hard_cnt != 1 || !hard_first))
				log_mismatch($sformatf("hard reset high %0d cycles, first cycle %b",
					hard_cnt, hard_first));
			if (!hard && hard_cnt != 0)
				log_mismatch("hard reset pulse without a hard toggle");
			if (o_dragon !== (mach != coco_tape_pkg::MACH_COCO2)
				|| o_dragon64 !== (mach == coco_tape_pkg::MACH_DRAGON64)
				|| o_disk_cart_en !== (disk && mach == coco_tape_pkg::MACH_COCO2))
				log_mismatch($sformatf("decode %b%b%b for machine %0d disk %b",
					o_dragon, o_dragon64, o_disk_cart_en, mach, disk));
		end
	endtask

	task automatic select_machine();
		int mark;
		begin
			mark = errors;
			change_machine(coco_tape_pkg::MACH_DRAGON32, 1'b0);
			change_machine(coco_tape_pkg::MACH_DRAGON64, 1'b0);
			change_machine(coco_tape_pkg::MACH_COCO2, 1'b0);
			change_machine(coco_tape_pkg::MACH_COCO2, 1'b1);
			change_machine(coco_tape_pkg::MACH_DRAGON32, 1'b1);
			close_test("select_machine", mark);
		end
	endtask

	task automatic mix_audio();
		int                                mark;
		logic [coco_tape_pkg::SOUND_W-1:0] snd;
		logic                              sndout;
		logic                              mon;
		logic                              cas;
		coco_tape_pkg::tape_audio_u        dec;
		begin
			mark = errors;
			// Monitor off for the first half, on for the second
			for (int k = 0; k < 2 * AUDIO_SAMPLES; k++)
			begin
				mon = (k >= AUDIO_SAMPLES);
				@(negedge clk_sys);
				snd            = coco_tape_pkg::SOUND_W'($random(seed));
				sndout         = 1'($random(seed));
				i_sound        = snd;
				i_sndout       = sndout;
				i_tape_monitor = mon;
				i_tape_src_adc = 1'($random(seed));
				// Mix uses the cassette bit held before the edge
				cas            = o_cas_bit;
				@(negedge clk_sys);
				dec.raw = o_audio;
				if (dec.f.sndout !== sndout || dec.f.snd_hi !== snd[11:6]
					|| dec.f.tape !== (snd[5] ^ (mon & cas)) || dec.f.snd_lo !== snd[4:0]
					|| dec.f.pad !== 3'b000)
					log_mismatch($sformatf("audio %h for sound %h sndout %b monitor %b tape %b",
						dec.raw, snd, sndout, mon, cas));
			end
			close_test("mix_audio", mark);
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////

	initial
	begin
		seed           = 86;
		errors         = 0;
		tests          = 0;
		tests_bad      = 0;
		handshakes     = 0;
		clk_sys        = 1'b0;
		i_reset        = 1'b1;
		i_machine      = coco_tape_pkg::MACH_COCO2;
		i_hard_toggle  = 1'b0;
		i_disk_sel     = 1'b0;
		i_load_valid   = 1'b0;
		i_load_addr    = '0;
		i_load_data    = '0;
		i_relay        = 1'b0;
		i_rewind       = 1'b0;
		i_adc_valid    = 1'b0;
		i_adc_data     = '0;
		i_tape_src_adc = 1'b0;
		i_tape_monitor = 1'b0;
		i_sound        = '0;
		i_sndout       = 1'b0;

		check_reset();
		load_and_play();
		load_during_play();
		slice_adc();
		select_machine();
		mix_audio();

		$display("Summary: %0d tests run, %0d with errors, %0d errors in total",
			tests, tests_bad, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Error: watchdog expired, the tests did not finish in time");
		$display("sim failed");
		$finish;
	end

endmodule

// ==== project.f ====
rtl/coco_tape_pkg.sv
rtl/tape_ram.sv
rtl/tape_adc_slicer.sv
rtl/tape_mem_arbiter.sv
rtl/tape_player.sv
rtl/machine_reset_seq.sv
rtl/coco_tape_top.sv
dv/tape_arbiter_checker.sv
dv/tb_coco_tape.sv

// ==== rtl/coco_tape_pkg.sv ====
// Shared widths and machine codes for the cassette path
// Audio output word with its raw and field views

package coco_tape_pkg;

	// Data path widths
	localparam int ADC_W       = 12;
	localparam int TAPE_DATA_W = 8;
	localparam int SOUND_W     = 12;

	// Machine select codes
	localparam logic [1:0] MACH_COCO2    = 2'd0;
	localparam logic [1:0] MACH_DRAGON32 = 2'd1;
	localparam logic [1:0] MACH_DRAGON64 = 2'd2;

	// Field layout of the audio word, top bit first
	typedef struct packed {
		logic       sndout;
		logic [5:0] snd_hi;
		// Sound bit 5 with the tape bit mixed in
		logic       tape;
		logic [4:0] snd_lo;
		logic [2:0] pad;
	} tape_audio_fields_t;

	// One 16 bit audio word seen two ways
	typedef union packed {
		logic [15:0]        raw;
		tape_audio_fields_t f;
	} tape_audio_u;

endpackage

// ==== rtl/coco_tape_top.sv ====
// Cassette path and machine control top level
// Tape load and playback, ADC slicer, source select, audio mix, reset sequencer

`timescale 1ns/1ps

module coco_tape_top #(
	parameter int AVG_LOG2      = 9,
	parameter int ADC_THRESHOLD = 100,
	parameter int TAPE_ADDR_W   = 12,
	parameter int BIT_PERIOD    = 32,
	parameter int RESET_STRETCH = 15
) (
	input  logic                                  clk_sys,
	input  logic                                  i_reset,
	input  logic [1:0]                            i_machine,
	input  logic                                  i_hard_toggle,
	input  logic                                  i_disk_sel,
	input  logic                                  i_load_valid,
	input  logic [TAPE_ADDR_W-1:0]                i_load_addr,
	input  logic [coco_tape_pkg::TAPE_DATA_W-1:0] i_load_data,
	input  logic                                  i_relay,
	input  logic                                  i_rewind,
	input  logic                                  i_adc_valid,
	input  logic [coco_tape_pkg::ADC_W-1:0]       i_adc_data,
	input  logic                                  i_tape_src_adc,
	input  logic                                  i_tape_monitor,
	input  logic [coco_tape_pkg::SOUND_W-1:0]     i_sound,
	input  logic                                  i_sndout,
	output logic                                  o_load_ready,
	output logic                                  o_cas_bit,
	output logic [15:0]                           o_audio,
	output logic                                  o_core_reset,
	output logic                                  o_hard_reset,
	output logic                                  o_dragon,
	output logic                                  o_dragon64,
	output logic                                  o_disk_cart_en
);

	logic                                  adc_bit;
	logic                                  player_bit;
	logic                                  rd_valid;
	logic                                  rd_ready;
	logic [TAPE_ADDR_W-1:0]                rd_addr;
	logic [coco_tape_pkg::TAPE_DATA_W-1:0] rd_data;
	logic                                  rd_data_valid;
	logic                                  cas_bit_r;
	logic [15:0]                           audio_r;
	coco_tape_pkg::tape_audio_u            audio_mix;

	//////////////////////////////////////////////////
	// Cassette sources
	//////////////////////////////////////////////////

	tape_adc_slicer #(
		.AVG_LOG2      (AVG_LOG2),
		.ADC_THRESHOLD (ADC_THRESHOLD)
	) tape_adc_slicer_inst (
		.clk_sys     (clk_sys),
		.i_reset     (i_reset),
		.i_adc_valid (i_adc_valid),
		.i_adc_data  (i_adc_data),
		.o_tape_bit  (adc_bit)
	);

	tape_mem_arbiter #(
		.TAPE_ADDR_W (TAPE_ADDR_W)
	) tape_mem_arbiter_inst (
		.clk_sys         (clk_sys),
		.i_reset         (i_reset),
		.i_load_valid    (i_load_valid),
		.i_load_addr     (i_load_addr),
		.i_load_data     (i_load_data),
		.i_rd_valid      (rd_valid),
		.i_rd_addr       (rd_addr),
		.o_load_ready    (o_load_ready),
		.o_rd_ready      (rd_ready),
		.o_rd_data       (rd_data),
		.o_rd_data_valid (rd_data_valid)
	);

	tape_player #(
		.TAPE_ADDR_W (TAPE_ADDR_W),
		.BIT_PERIOD  (BIT_PERIOD)
	) tape_player_inst (
		.clk_sys         (clk_sys),
		.i_reset         (i_reset),
		.i_relay         (i_relay),
		.i_rewind        (i_rewind),
		.i_rd_ready      (rd_ready),
		.i_rd_data       (rd_data),
		.i_rd_data_valid (rd_data_valid),
		.o_rd_valid      (rd_valid),
		.o_rd_addr       (rd_addr),
		.o_tape_bit      (player_bit)
	);

	machine_reset_seq #(
		.RESET_STRETCH (RESET_STRETCH)
	) machine_reset_seq_inst (
		.clk_sys        (clk_sys),
		.i_reset        (i_reset),
		.i_machine      (i_machine),
		.i_hard_toggle  (i_hard_toggle),
		.i_disk_sel     (i_disk_sel),
		.o_core_reset   (o_core_reset),
		.o_hard_reset   (o_hard_reset),
		.o_dragon       (o_dragon),
		.o_dragon64     (o_dragon64),
		.o_disk_cart_en (o_disk_cart_en)
	);

	//////////////////////////////////////////////////
	// Source select and audio mix
	//////////////////////////////////////////////////

	always_comb
	begin
		// 1 bit sound loudest, then core sound, tape bit lowest in level
		audio_mix.f.sndout = i_sndout;
		audio_mix.f.snd_hi = i_sound[11:6];
		audio_mix.f.tape   = i_sound[5] ^ (i_tape_monitor && cas_bit_r);
		audio_mix.f.snd_lo = i_sound[4:0];
		audio_mix.f.pad    = '0;
	end

	always_ff @(posedge clk_sys)
	begin
		if (i_reset)
		begin
			cas_bit_r <= 1'b0;
			audio_r   <= '0;
		end
		else
		begin
			cas_bit_r <= i_tape_src_adc ? adc_bit : player_bit;
			audio_r   <= audio_mix.raw;
		end
	end

	assign o_cas_bit = cas_bit_r;
	assign o_audio   = audio_r;

endmodule

// ==== rtl/machine_reset_seq.sv ====
// Machine type decode
// Core reset stretch on a machine change and hard reset pulse

`timescale 1ns/1ps

module machine_reset_seq #(
	parameter int RESET_STRETCH = 15
) (
	input  logic       clk_sys,
	input  logic       i_reset,
	input  logic [1:0] i_machine,
	input  logic       i_hard_toggle,
	input  logic       i_disk_sel,
	output logic       o_core_reset,
	output logic       o_hard_reset,
	output logic       o_dragon,
	output logic       o_dragon64,
	output logic       o_disk_cart_en
);

	localparam int CNT_W = $clog2(RESET_STRETCH + 1);

	logic [1:0]       mach_prev_r;
	logic             toggle_prev_r;
	logic [CNT_W-1:0] stretch_cnt_r;
	logic             hard_pulse_r;
	logic             mach_event;
	logic             toggle_event;

	always_comb
	begin
		mach_event   = i_machine != mach_prev_r;
		toggle_event = i_hard_toggle != toggle_prev_r;
	end

	always_ff @(posedge clk_sys)
	begin
		if (i_reset)
		begin
			// Track the inputs so release does not look like a change
			mach_prev_r    <= i_machine;
			toggle_prev_r  <= i_hard_toggle;
			stretch_cnt_r  <= '0;
			hard_pulse_r   <= 1'b0;
			o_dragon       <= 1'b0;
			o_dragon64     <= 1'b0;
			o_disk_cart_en <= 1'b0;
		end
		else
		begin
			mach_prev_r   <= i_machine;
			toggle_prev_r <= i_hard_toggle;

			// Either event restarts the stretch
			if (mach_event || toggle_event)
				stretch_cnt_r <= CNT_W'(RESET_STRETCH);
			else if (stretch_cnt_r != '0)
				stretch_cnt_r <= stretch_cnt_r - 1'b1;

			// Hard reset only on the first stretched cycle
			hard_pulse_r <= toggle_event;

			o_dragon       <= i_machine != coco_tape_pkg::MACH_COCO2;
			o_dragon64     <= i_machine == coco_tape_pkg::MACH_DRAGON64;
			o_disk_cart_en <= i_disk_sel && (i_machine == coco_tape_pkg::MACH_COCO2);
		end
	end

	assign o_core_reset = i_reset || (stretch_cnt_r != '0);
	assign o_hard_reset = hard_pulse_r;

endmodule

// ==== rtl/tape_adc_slicer.sv ====
// ADC cassette bit detector
// Running average over the last 2^AVG_LOG2 samples with a hysteresis threshold

`timescale 1ns/1ps

module tape_adc_slicer #(
	parameter int AVG_LOG2      = 9,
	parameter int ADC_THRESHOLD = 100
) (
	input  logic                             clk_sys,
	input  logic                             i_reset,
	input  logic                             i_adc_valid,
	input  logic [coco_tape_pkg::ADC_W-1:0]  i_adc_data,
	output logic                             o_tape_bit
);

	localparam int DEPTH = 2 ** AVG_LOG2;
	localparam int TOT_W = coco_tape_pkg::ADC_W + AVG_LOG2;
	// Two spare bits so sample plus threshold cannot wrap
	localparam int CMP_W = coco_tape_pkg::ADC_W + 2;
	localparam logic [CMP_W-1:0] THR_EXT = CMP_W'(ADC_THRESHOLD);

	logic [coco_tape_pkg::ADC_W-1:0] sample_buf [DEPTH];
	logic [AVG_LOG2-1:0]             wr_ptr;
	logic [TOT_W-1:0]                total_r;
	logic [coco_tape_pkg::ADC_W-1:0] avg_r;
	logic                            tape_bit_r;

	logic [TOT_W-1:0] total_next;
	logic [CMP_W-1:0] s_ext;
	logic [CMP_W-1:0] avg_ext;

	//////////////////////////////////////////////////
	// Running total
	//////////////////////////////////////////////////

	always_comb
	begin
		// New sample in, the oldest one out
		total_next = total_r + TOT_W'(i_adc_data) - TOT_W'(sample_buf[wr_ptr]);
		s_ext      = CMP_W'(i_adc_data);
		avg_ext    = CMP_W'(avg_r);
	end

	//////////////////////////////////////////////////
	// Sample history and slicer bit
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys)
	begin
		if (i_reset)
		begin
			for (int i = 0; i < DEPTH; i++)
			begin
				sample_buf[i] <= '0;
			end
			wr_ptr     <= '0;
			total_r    <= '0;
			avg_r      <= '0;
			tape_bit_r <= 1'b0;
		end
		else if (i_adc_valid)
		begin
			// Compare against the average held before this sample
			// Input well below average reads as a one
			// Same polarity as on the real machine
			if ((s_ext + THR_EXT) < avg_ext)
				tape_bit_r <= 1'b1;
			else if (s_ext > (avg_ext + THR_EXT))
				tape_bit_r <= 1'b0;

			sample_buf[wr_ptr] <= i_adc_data;
			wr_ptr             <= wr_ptr + 1'b1;
			total_r            <= total_next;
			// Divide by the window size
			avg_r              <= total_next[TOT_W-1:AVG_LOG2];
		end
	end

	assign o_tape_bit = tape_bit_r;

endmodule

// ==== rtl/tape_mem_arbiter.sv ====
// Round-robin sharing of the tape memory
// Loader writes and player reads onto one RAM port, with read data valid

`timescale 1ns/1ps

module tape_mem_arbiter #(
	parameter int TAPE_ADDR_W = 12
) (
	input  logic                                  clk_sys,
	input  logic                                  i_reset,
	input  logic                                  i_load_valid,
	input  logic [TAPE_ADDR_W-1:0]                i_load_addr,
	input  logic [coco_tape_pkg::TAPE_DATA_W-1:0] i_load_data,
	input  logic                                  i_rd_valid,
	input  logic [TAPE_ADDR_W-1:0]                i_rd_addr,
	output logic                                  o_load_ready,
	output logic                                  o_rd_ready,
	output logic [coco_tape_pkg::TAPE_DATA_W-1:0] o_rd_data,
	output logic                                  o_rd_data_valid
);

	logic contest;
	logic load_grant;
	logic rd_grant;
	// Set when the player is due to win the next contest
	logic prefer_rd_r;
	logic rd_data_valid_r;

	logic                                  ram_we;
	logic [TAPE_ADDR_W-1:0]                ram_addr;
	logic [coco_tape_pkg::TAPE_DATA_W-1:0] ram_wdata;
	logic [coco_tape_pkg::TAPE_DATA_W-1:0] ram_rdata;

	//////////////////////////////////////////////////
	// Grant
	//////////////////////////////////////////////////

	always_comb
	begin
		contest    = i_load_valid && i_rd_valid;
		// A lone requester always wins
		load_grant = i_load_valid && !(i_rd_valid && prefer_rd_r);
		rd_grant   = i_rd_valid && !(i_load_valid && !prefer_rd_r);

		// Single RAM port follows the grant
		ram_we    = load_grant;
		ram_addr  = load_grant ? i_load_addr : i_rd_addr;
		ram_wdata = i_load_data;
	end

	always_ff @(posedge clk_sys)
	begin
		if (i_reset)
		begin
			// Loader takes the first contest
			prefer_rd_r     <= 1'b0;
			rd_data_valid_r <= 1'b0;
		end
		else
		begin
			// Only contested cycles flip the priority
			if (contest)
				prefer_rd_r <= !prefer_rd_r;
			// RAM read latency is one cycle
			rd_data_valid_r <= rd_grant;
		end
	end

	tape_ram #(
		.TAPE_ADDR_W (TAPE_ADDR_W)
	) tape_ram_inst (
		.clk_sys (clk_sys),
		.i_we    (ram_we),
		.i_addr  (ram_addr),
		.i_wdata (ram_wdata),
		.o_rdata (ram_rdata)
	);

	assign o_load_ready    = load_grant;
	assign o_rd_ready      = rd_grant;
	assign o_rd_data       = ram_rdata;
	assign o_rd_data_valid = rd_data_valid_r;

endmodule

// ==== rtl/tape_player.sv ====
// Cassette playback from the tape memory
// Byte fetch with one byte prefetch, MSB first serial output
// Motor relay and rewind control

`timescale 1ns/1ps

module tape_player #(
	parameter int TAPE_ADDR_W = 12,
	parameter int BIT_PERIOD  = 32
) (
	input  logic                                  clk_sys,
	input  logic                                  i_reset,
	input  logic                                  i_relay,
	input  logic                                  i_rewind,
	input  logic                                  i_rd_ready,
	input  logic [coco_tape_pkg::TAPE_DATA_W-1:0] i_rd_data,
	input  logic                                  i_rd_data_valid,
	output logic                                  o_rd_valid,
	output logic [TAPE_ADDR_W-1:0]                o_rd_addr,
	output logic                                  o_tape_bit
);

	localparam int DW    = coco_tape_pkg::TAPE_DATA_W;
	localparam int BIT_W = $clog2(DW);
	localparam int PER_W = $clog2(BIT_PERIOD + 1);

	// Fetch side
	logic [TAPE_ADDR_W-1:0] addr_r;
	logic [TAPE_ADDR_W-1:0] req_addr_r;
	logic                   rd_valid_r;
	logic                   rd_pending_r;
	// Read in flight across a rewind, its data is thrown away
	logic                   drop_r;
	logic [DW-1:0]          pref_buf_r;
	logic                   pref_full_r;

	// Serial side
	logic [DW-1:0]    shift_r;
	logic             active_r;
	logic [BIT_W-1:0] bit_idx_r;
	logic [PER_W-1:0] per_cnt_r;

	logic accept;
	logic issue;
	logic bit_end;
	logic byte_end;
	logic load_shift;

	always_comb
	begin
		accept     = rd_valid_r && i_rd_ready;
		// One read at a time and only into an empty prefetch slot
		issue      = i_relay && !i_rewind && !rd_valid_r && !rd_pending_r && !pref_full_r;
		bit_end    = active_r && (per_cnt_r == PER_W'(BIT_PERIOD - 1));
		byte_end   = bit_end && (bit_idx_r == BIT_W'(DW - 1));
		load_shift = i_relay && pref_full_r && (!active_r || byte_end);
	end

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys)
	begin
		if (i_reset)
		begin
			addr_r       <= '0;
			rd_valid_r   <= 1'b0;
			rd_pending_r <= 1'b0;
			drop_r       <= 1'b0;
			pref_full_r  <= 1'b0;
			shift_r      <= '0;
			active_r     <= 1'b0;
			bit_idx_r    <= '0;
			per_cnt_r    <= '0;
		end
		else
		begin
			// Request held until the arbiter takes it
			if (issue)
				rd_valid_r <= 1'b1;
			else if (accept)
				rd_valid_r <= 1'b0;

			if (accept)
				rd_pending_r <= 1'b1;
			else if (i_rd_data_valid)
				rd_pending_r <= 1'b0;

			// Address wraps at the end of memory
			if (issue)
				addr_r <= addr_r + 1'b1;

			if (i_rewind)
			begin
				addr_r      <= '0;
				drop_r      <= rd_valid_r || (rd_pending_r && !i_rd_data_valid);
				pref_full_r <= 1'b0;
				shift_r     <= '0;
				active_r    <= 1'b0;
				bit_idx_r   <= '0;
				per_cnt_r   <= '0;
			end
			else
			begin
				if (i_rd_data_valid)
				begin
					if (drop_r)
						drop_r <= 1'b0;
					else
						pref_full_r <= 1'b1;
				end

				// Next byte moves in as the last bit ends
				if (load_shift)
				begin
					shift_r     <= pref_buf_r;
					pref_full_r <= 1'b0;
					active_r    <= 1'b1;
					bit_idx_r   <= '0;
					per_cnt_r   <= '0;
				end
				else if (i_relay && active_r)
				begin
					if (bit_end)
					begin
						per_cnt_r <= '0;
						// No byte ready, hold the current level
						if (byte_end)
							active_r <= 1'b0;
						else
						begin
							shift_r   <= shift_r << 1;
							bit_idx_r <= bit_idx_r + 1'b1;
						end
					end
					else
						per_cnt_r <= per_cnt_r + 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Payload
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys)
	begin
		if (i_rd_data_valid)
			pref_buf_r <= i_rd_data;
		if (issue)
			req_addr_r <= addr_r;
	end

	assign o_rd_valid = rd_valid_r;
	assign o_rd_addr  = req_addr_r;
	assign o_tape_bit = shift_r[DW-1];

endmodule

// ==== rtl/tape_ram.sv ====
// Tape image byte memory
// Single port, write or read each cycle, read data one cycle later

`timescale 1ns/1ps

module tape_ram #(
	parameter int TAPE_ADDR_W = 12
) (
	input  logic                                  clk_sys,
	input  logic                                  i_we,
	input  logic [TAPE_ADDR_W-1:0]                i_addr,
	input  logic [coco_tape_pkg::TAPE_DATA_W-1:0] i_wdata,
	output logic [coco_tape_pkg::TAPE_DATA_W-1:0] o_rdata
);

	logic [coco_tape_pkg::TAPE_DATA_W-1:0] mem [2 ** TAPE_ADDR_W];

	// Registered read so the array maps onto block RAM
	always_ff @(posedge clk_sys)
	begin
		if (i_we)
			mem[i_addr] <= i_wdata;
		o_rdata <= mem[i_addr];
	end

endmodule
